// ==== IssueStage.f ====
+incdir+include
verilog/SchedulerPkg.sv
verilog/Picker.sv
verilog/SelectLogic.sv
verilog/WakeupLogic.sv
verilog/IssueQueue.sv
verilog/IssueRegister.sv
verilog/IssueStage.sv
verification/IssueStageTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= IssueStageTb
FILELIST ?= IssueStage.f
FLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== include/scheduler_consts.svh ====
/*
 * Scheduler constants
 * Sizes of the issue queue, the issue lanes and the op fields
 */

`ifndef SCHEDULER_CONSTS_SVH
`define SCHEDULER_CONSTS_SVH

// Issue queue depth
`define ISSUE_QUEUE_ENTRY_NUM 8

// Issue lanes, integer lanes first, then memory
`define INT_ISSUE_WIDTH 2
`define MEM_ISSUE_WIDTH 1
`define ISSUE_WIDTH (`INT_ISSUE_WIDTH + `MEM_ISSUE_WIDTH)

// Physical register tag
`define PREG_TAG_WIDTH 6

// Op payload word, decoded per lane
`define PAYLOAD_WIDTH 16

`endif

// ==== verification/IssueStageTb.sv ====
/*
 * Issue stage testbench
 * Directed and random dispatch against a tag-readiness model and
 * a scoreboard of outstanding ops keyed by destination tag
 */

`timescale 1ns/1ps

`include "scheduler_consts.svh"

module IssueStageTb
    import SchedulerPkg::*;
();

    localparam int INT_W = `INT_ISSUE_WIDTH;
    localparam int MEM_LANE = `INT_ISSUE_WIDTH;
    localparam int NEVER = 1 << 30;
    localparam int CHAIN_CYCLES = 10;
    localparam int EXT_CYCLES = 15;
    localparam int MEM_CYCLES = 30;
    localparam int FLUSH_CYCLES = 20;
    localparam int RANDOM_CYCLES = 400;
    localparam int DRAIN_MARGIN = 50;
    localparam int TIMEOUT_CYCLES = 5 + CHAIN_CYCLES + EXT_CYCLES + MEM_CYCLES
        + FLUSH_CYCLES + RANDOM_CYCLES + 5 * DRAIN_MARGIN;

    logic clk;
    logic arstN;
    logic flush;
    logic memReady;
    logic dispatchValid;
    logic dispatchReady;
    OpClass dispatchClass;
    OpPayload dispatchPayload;
    PRegTag dispatchDstTag;
    PRegTag dispatchSrcTag [2];
    logic dispatchSrcReady [2];
    logic extWakeupValid;
    PRegTag extWakeupTag;
    logic issueValid [`ISSUE_WIDTH];
    PRegTag issueDstTag [`ISSUE_WIDTH];
    logic [3:0] aluOpcode [`INT_ISSUE_WIDTH];
    logic [11:0] aluImm [`INT_ISSUE_WIDTH];
    logic memIsStore;
    logic [1:0] memSize;
    logic [12:0] memOffset;

    // Reference model, indexed by tag
    int edgeCount = 0;
    int outstandingCount = 0;
    bit outstanding [64];
    bit opIsMem [64];
    logic [15:0] opPayload [64];
    int acceptEdge [64];
    int issueEdge [64];
    PRegTag opSrc [64][2];
    int opSrcEdge [64][2];
    int tagReadyEdge [64];
    logic [31:0] rngState = 32'd50411;
    string testName = "reset";

    IssueStage u_dut (
        .clk(clk),
        .arstN(arstN),
        .flush(flush),
        .memReady(memReady),
        .dispatchValid(dispatchValid),
        .dispatchReady(dispatchReady),
        .dispatchClass(dispatchClass),
        .dispatchPayload(dispatchPayload),
        .dispatchDstTag(dispatchDstTag),
        .dispatchSrcTag(dispatchSrcTag),
        .dispatchSrcReady(dispatchSrcReady),
        .extWakeupValid(extWakeupValid),
        .extWakeupTag(extWakeupTag),
        .issueValid(issueValid),
        .issueDstTag(issueDstTag),
        .aluOpcode(aluOpcode),
        .aluImm(aluImm),
        .memIsStore(memIsStore),
        .memSize(memSize),
        .memOffset(memOffset)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        edgeCount++;
        if (edgeCount > TIMEOUT_CYCLES) begin
            $display("Timeout in %s after %0d cycles", testName, edgeCount);
            $display("Regression failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic randomWord(output logic [31:0] r);
        rngState = xorshift(rngState);
        r = rngState;
    endtask

    task automatic reportMismatch(input string what, input int expected, input int actual);
        $display("Mismatch in %s: %s expected %0h actual %0h", testName, what, expected, actual);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic reportFailure(input string what);
        $display("Error in %s: %s", testName, what);
        $display("Regression failed");
        $fatal(1);
    endtask

    // A broadcast visible in the cycle ending at edge r
    task automatic wakeTag(input PRegTag t, input int r);
        if (r < tagReadyEdge[t]) begin
            tagReadyEdge[t] = r;
        end
        for (int o = 0; o < 64; o++) begin
            for (int s = 0; s < 2; s++) begin
                if (outstanding[o] && opSrc[o][s] == t && opSrcEdge[o][s] == NEVER) begin
                    opSrcEdge[o][s] = r;
                end
            end
        end
    endtask

    // Outputs after edge edgeCount, inputs still those of the cycle that ended
    task automatic checkCycle();
        PRegTag t;
        int earliest;
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            if (issueValid[k]) begin
                t = issueDstTag[k];
                for (int j = 0; j < k; j++) begin
                    assert (!(issueValid[j] && issueDstTag[j] == t))
                        else reportFailure("same destination tag on two lanes");
                end
                assert (!flush) else reportFailure("op issued right after a flush");
                assert (outstanding[t]) else reportFailure("issued op is not outstanding");
                assert (opIsMem[t] == (k >= INT_W))
                    else reportMismatch("lane class", opIsMem[t], k >= INT_W);
                if (k < INT_W) begin
                    assert (aluOpcode[k] == opPayload[t][15:12])
                        else reportMismatch("aluOpcode", opPayload[t][15:12], aluOpcode[k]);
                    assert (aluImm[k] == opPayload[t][11:0])
                        else reportMismatch("aluImm", opPayload[t][11:0], aluImm[k]);
                end else begin
                    assert (memIsStore == opPayload[t][15])
                        else reportMismatch("memIsStore", opPayload[t][15], memIsStore);
                    assert (memSize == opPayload[t][14:13])
                        else reportMismatch("memSize", opPayload[t][14:13], memSize);
                    assert (memOffset == opPayload[t][12:0])
                        else reportMismatch("memOffset", opPayload[t][12:0], memOffset);
                end
                earliest = acceptEdge[t];
                for (int s = 0; s < 2; s++) begin
                    if (opSrcEdge[t][s] > earliest) begin
                        earliest = opSrcEdge[t][s];
                    end
                end
                assert (edgeCount > earliest)
                    else reportFailure("op issued before its sources were ready");
                outstanding[t] = 1'b0;
                outstandingCount--;
                issueEdge[t] = edgeCount;
                wakeTag(t, edgeCount + 1);
            end
        end
        assert (memReady || !issueValid[MEM_LANE])
            else reportFailure("memory op issued while memReady was low");
        assert (issueValid[MEM_LANE] || !memIsStore)
            else reportFailure("memIsStore high on an idle memory lane");
        if (flush) begin
            for (int o = 0; o < 64; o++) begin
                outstanding[o] = 1'b0;
            end
            outstandingCount = 0;
            assert (dispatchReady) else reportFailure("dispatchReady low after flush");
        end
    endtask

    task automatic step();
        @(negedge clk);
        checkCycle();
        dispatchValid = 1'b0;
        dispatchSrcReady[0] = 1'b0;
        dispatchSrcReady[1] = 1'b0;
        extWakeupValid = 1'b0;
        flush = 1'b0;
    endtask

    task automatic dispatchOp(input bit isMem, input logic [15:0] payload, input PRegTag dst,
            input PRegTag src0, input PRegTag src1, output bit accepted);
        PRegTag src [2];
        src[0] = src0;
        src[1] = src1;
        dispatchValid = 1'b1;
        dispatchClass = isMem ? MEM : INT;
        dispatchPayload = OpPayload'(payload);
        dispatchDstTag = dst;
        for (int s = 0; s < 2; s++) begin
            dispatchSrcTag[s] = src[s];
            // Broadcasts visible now are caught by the same-cycle path
            dispatchSrcReady[s] = tagReadyEdge[src[s]] <= edgeCount;
        end
        accepted = dispatchReady;
        if (accepted) begin
            outstanding[dst] = 1'b1;
            outstandingCount++;
            opIsMem[dst] = isMem;
            opPayload[dst] = payload;
            acceptEdge[dst] = edgeCount + 1;
            issueEdge[dst] = NEVER;
            for (int s = 0; s < 2; s++) begin
                opSrc[dst][s] = src[s];
                opSrcEdge[dst][s] = (tagReadyEdge[src[s]] <= edgeCount + 1) ? edgeCount + 1 : NEVER;
            end
            tagReadyEdge[dst] = NEVER;
        end
    endtask

    task automatic announce(input PRegTag t);
        extWakeupValid = 1'b1;
        extWakeupTag = t;
        wakeTag(t, edgeCount + 1);
    endtask

    task automatic drain();
        memReady = 1'b1;
        while (outstandingCount > 0) begin
            step();
        end
    endtask

    initial begin
        bit acc;
        int wakeEdge;
        int ringPos;
        PRegTag nextDst;
        PRegTag ring [8];
        logic [31:0] r;
        logic [31:0] p;

        arstN = 1'b0;
        flush = 1'b0;
        memReady = 1'b1;
        dispatchValid = 1'b0;
        dispatchClass = INT;
        dispatchPayload = '0;
        dispatchDstTag = '0;
        dispatchSrcTag[0] = '0;
        dispatchSrcTag[1] = '0;
        dispatchSrcReady[0] = 1'b0;
        dispatchSrcReady[1] = 1'b0;
        extWakeupValid = 1'b0;
        extWakeupTag = '0;
        for (int o = 0; o < 64; o++) begin
            outstanding[o] = 1'b0;
            tagReadyEdge[o] = NEVER;
        end
        // Tag 63 stands for an operand that is always ready
        tagReadyEdge[63] = 0;
        repeat (5) @(negedge clk);
        arstN = 1'b1;
        assert (dispatchReady) else reportFailure("dispatchReady low after reset");
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            assert (issueValid[k] === 1'b0) else reportFailure("issueValid set after reset");
        end

        testName = "chain";
        step();
        dispatchOp(1'b0, 16'h1abc, 6'd0, 6'd63, 6'd63, acc);
        step();
        dispatchOp(1'b0, 16'h2def, 6'd1, 6'd0, 6'd63, acc);
        step();
        drain();
        assert (issueEdge[0] == acceptEdge[0] + 1)
            else reportMismatch("producer issue edge", acceptEdge[0] + 1, issueEdge[0]);
        assert (issueEdge[1] == issueEdge[0] + 2)
            else reportMismatch("consumer issue edge", issueEdge[0] + 2, issueEdge[1]);

        testName = "extWakeup";
        step();
        dispatchOp(1'b0, 16'h3456, 6'd2, 6'd50, 6'd63, acc);
        repeat (5) step();
        announce(6'd50);
        wakeEdge = edgeCount + 1;
        step();
        drain();
        assert (issueEdge[2] == wakeEdge + 1)
            else reportMismatch("woken op issue edge", wakeEdge + 1, issueEdge[2]);

        testName = "memBackpressure";
        step();
        memReady = 1'b0;
        for (int i = 0; i < 7; i++) begin
            step();
            randomWord(p);
            dispatchOp(1'b1, p[15:0], PRegTag'(4 + i), 6'd63, 6'd63, acc);
            assert (acc) else reportFailure("memory op refused with free entries");
        end
        step();
        dispatchOp(1'b0, 16'h4321, 6'd3, 6'd63, 6'd63, acc);
        repeat (3) step();
        assert (!outstanding[3]) else reportFailure("integer op stuck behind memory ops");
        dispatchOp(1'b1, 16'h8123, 6'd11, 6'd63, 6'd63, acc);
        step();
        assert (!dispatchReady) else reportFailure("full queue still shows dispatchReady");
        drain();

        testName = "flush";
        // Full queue of waiting ops, then flush
        for (int i = 0; i < 8; i++) begin
            step();
            dispatchOp(i[0], 16'h5000 + i[15:0], PRegTag'(20 + i), 6'd51, 6'd63, acc);
            assert (acc) else reportFailure("op refused with free entries");
        end
        step();
        flush = 1'b1;
        step();
        // A ready op selected at the flush edge, and a dispatch in the flush cycle
        dispatchOp(1'b0, 16'h5a5a, 6'd28, 6'd63, 6'd63, acc);
        step();
        flush = 1'b1;
        dispatchOp(1'b1, 16'h5b5b, 6'd29, 6'd63, 6'd63, acc);
        step();
        announce(6'd51);
        repeat (5) step();

        testName = "random";
        for (int i = 0; i < 8; i++) begin
            ring[i] = 6'd63;
        end
        ringPos = 0;
        nextDst = 6'd12;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            step();
            randomWord(r);
            memReady = r[2:0] != 3'd0;
            if (r[31:30] != 2'd0 && !outstanding[nextDst]) begin
                randomWord(p);
                dispatchOp(r[4], p[15:0], nextDst, r[5] ? 6'd63 : ring[r[8:6]],
                    r[9] ? 6'd63 : ring[r[12:10]], acc);
                if (acc) begin
                    ring[ringPos] = nextDst;
                    ringPos = (ringPos + 1) % 8;
                    nextDst = (nextDst == 6'd47) ? 6'd12 : nextDst + 6'd1;
                end
            end
            if (r[20:16] == 5'd0) begin
                announce(ring[r[23:21]]);
            end
        end
        step();
        drain();

        $display("Regression passed");
        $finish;
    end

endmodule : IssueStageTb

// ==== verilog/IssueQueue.sv ====
/*
 * Issue queue
 * Holds dispatched ops, allocates the lowest free entry and
 * releases entries once they are granted
 */

`timescale 1ns/1ps

`include "scheduler_consts.svh"

module IssueQueue
    import SchedulerPkg::*;
(
    input logic clk,
    input logic arstN,
    input logic flush,

    input logic dispatchValid,
    output logic dispatchReady,
    input OpClass dispatchClass,
    input OpPayload dispatchPayload,
    input PRegTag dispatchDstTag,

    output logic allocValid,
    output IssueQueueIndexPath allocPtr,

    output IssueQueueOneHotPath intIssueReq,
    output IssueQueueOneHotPath memIssueReq,

    input logic selected [`ISSUE_WIDTH],
    input IssueQueueIndexPath selectedPtr [`ISSUE_WIDTH],
    output OpPayload selectedPayload [`ISSUE_WIDTH],
    output PRegTag selectedDstTag [`ISSUE_WIDTH]
);

    IssueQueueOneHotPath entryValid;
    OpClass entryClass [`ISSUE_QUEUE_ENTRY_NUM];
    OpPayload entryPayload [`ISSUE_QUEUE_ENTRY_NUM];
    PRegTag entryDstTag [`ISSUE_QUEUE_ENTRY_NUM];

    logic anyFree;
    IssueQueueOneHotPath releaseVector;
    IssueQueueOneHotPath allocVector;

    always_comb begin
        // Lowest free entry
        anyFree = 1'b0;
        allocPtr = '0;
        for (int i = 0; i < `ISSUE_QUEUE_ENTRY_NUM; i++) begin
            if (!entryValid[i] && !anyFree) begin
                allocPtr = IssueQueueIndexPath'(i);
                anyFree = 1'b1;
            end
        end
        dispatchReady = anyFree;
        allocValid = dispatchValid && anyFree;

        allocVector = '0;
        allocVector[allocPtr] = allocValid;

        releaseVector = '0;
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            if (selected[k]) begin
                releaseVector[selectedPtr[k]] = 1'b1;
            end
        end

        for (int i = 0; i < `ISSUE_QUEUE_ENTRY_NUM; i++) begin
            intIssueReq[i] = entryValid[i] && (entryClass[i] == INT);
            memIssueReq[i] = entryValid[i] && (entryClass[i] == MEM);
        end

        // Read out for the issue register
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            selectedPayload[k] = entryPayload[selectedPtr[k]];
            selectedDstTag[k] = entryDstTag[selectedPtr[k]];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
        end else if (flush) begin
            entryValid <= '0;
        end else begin
            entryValid <= (entryValid & ~releaseVector) | allocVector;
        end
    end

    always_ff @(posedge clk) begin
        if (allocValid) begin
            entryClass[allocPtr] <= dispatchClass;
            entryPayload[allocPtr] <= dispatchPayload;
            entryDstTag[allocPtr] <= dispatchDstTag;
        end
    end

endmodule : IssueQueue

// ==== verilog/IssueRegister.sv ====
/*
 * Issue register
 * Registers granted ops per lane and decodes each payload
 * as ALU fields or memory fields
 */

`timescale 1ns/1ps

`include "scheduler_consts.svh"

module IssueRegister
    import SchedulerPkg::*;
(
    input logic clk,
    input logic arstN,
    input logic flush,
    input logic selected [`ISSUE_WIDTH],
    input OpPayload selectedPayload [`ISSUE_WIDTH],
    input PRegTag selectedDstTag [`ISSUE_WIDTH],
    output logic issueValid [`ISSUE_WIDTH],
    output PRegTag issueDstTag [`ISSUE_WIDTH],
    output logic [3:0] aluOpcode [`INT_ISSUE_WIDTH],
    output logic [11:0] aluImm [`INT_ISSUE_WIDTH],
    output logic memIsStore,
    output logic [1:0] memSize,
    output logic [12:0] memOffset
);

    localparam int MEM_LANE = `INT_ISSUE_WIDTH;

    OpPayload payload [`ISSUE_WIDTH];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < `ISSUE_WIDTH; k++) begin
                issueValid[k] <= 1'b0;
            end
        end else begin
            for (int k = 0; k < `ISSUE_WIDTH; k++) begin
                issueValid[k] <= selected[k] && !flush;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            if (selected[k]) begin
                payload[k] <= selectedPayload[k];
                issueDstTag[k] <= selectedDstTag[k];
            end
        end
    end

    // Integer lanes see the ALU view
    always_comb begin
        for (int k = 0; k < `INT_ISSUE_WIDTH; k++) begin
            aluOpcode[k] = payload[k].alu.aluOpcode;
            aluImm[k] = payload[k].alu.aluImm;
        end
    end

    // Memory lane sees the memory view, store strobe only with a valid op
    assign memIsStore = issueValid[MEM_LANE] && payload[MEM_LANE].mem.isStore;
    assign memSize = payload[MEM_LANE].mem.accessSize;
    assign memOffset = payload[MEM_LANE].mem.offset;

endmodule : IssueRegister

// ==== verilog/IssueStage.sv ====
/*
 * Issue stage
 * Queue, wakeup, select and issue register of the scheduler
 */

`timescale 1ns/1ps

`include "scheduler_consts.svh"

module IssueStage
    import SchedulerPkg::*;
(
    input logic clk,
    input logic arstN,
    input logic flush,
    input logic memReady,

    input logic dispatchValid,
    output logic dispatchReady,
    input OpClass dispatchClass,
    input OpPayload dispatchPayload,
    input PRegTag dispatchDstTag,
    input PRegTag dispatchSrcTag [2],
    input logic dispatchSrcReady [2],

    input logic extWakeupValid,
    input PRegTag extWakeupTag,

    output logic issueValid [`ISSUE_WIDTH],
    output PRegTag issueDstTag [`ISSUE_WIDTH],
    output logic [3:0] aluOpcode [`INT_ISSUE_WIDTH],
    output logic [11:0] aluImm [`INT_ISSUE_WIDTH],
    output logic memIsStore,
    output logic [1:0] memSize,
    output logic [12:0] memOffset
);

    logic allocValid;
    IssueQueueIndexPath allocPtr;
    IssueQueueOneHotPath intIssueReq;
    IssueQueueOneHotPath memIssueReq;
    IssueQueueOneHotPath opReady;

    logic selected [`ISSUE_WIDTH];
    IssueQueueIndexPath selectedPtr [`ISSUE_WIDTH];
    IssueQueueOneHotPath selectedVector [`ISSUE_WIDTH];
    OpPayload selectedPayload [`ISSUE_WIDTH];
    PRegTag selectedDstTag [`ISSUE_WIDTH];

    IssueQueue u_queue (
        .clk(clk),
        .arstN(arstN),
        .flush(flush),
        .dispatchValid(dispatchValid),
        .dispatchReady(dispatchReady),
        .dispatchClass(dispatchClass),
        .dispatchPayload(dispatchPayload),
        .dispatchDstTag(dispatchDstTag),
        .allocValid(allocValid),
        .allocPtr(allocPtr),
        .intIssueReq(intIssueReq),
        .memIssueReq(memIssueReq),
        .selected(selected),
        .selectedPtr(selectedPtr),
        .selectedPayload(selectedPayload),
        .selectedDstTag(selectedDstTag)
    );

    // Issue outputs double as the wakeup broadcast
    WakeupLogic u_wakeup (
        .clk(clk),
        .arstN(arstN),
        .flush(flush),
        .allocValid(allocValid),
        .allocPtr(allocPtr),
        .dispatchSrcTag(dispatchSrcTag),
        .dispatchSrcReady(dispatchSrcReady),
        .selectedVector(selectedVector),
        .issueValid(issueValid),
        .issueDstTag(issueDstTag),
        .extWakeupValid(extWakeupValid),
        .extWakeupTag(extWakeupTag),
        .opReady(opReady)
    );

    SelectLogic u_select (
        .opReady(opReady),
        .intIssueReq(intIssueReq),
        .memIssueReq(memIssueReq),
        .memReady(memReady),
        .selected(selected),
        .selectedPtr(selectedPtr),
        .selectedVector(selectedVector)
    );

    IssueRegister u_issueReg (
        .clk(clk),
        .arstN(arstN),
        .flush(flush),
        .selected(selected),
        .selectedPayload(selectedPayload),
        .selectedDstTag(selectedDstTag),
        .issueValid(issueValid),
        .issueDstTag(issueDstTag),
        .aluOpcode(aluOpcode),
        .aluImm(aluImm),
        .memIsStore(memIsStore),
        .memSize(memSize),
        .memOffset(memOffset)
    );

endmodule : IssueStage

// ==== verilog/Picker.sv ====
/*
 * Picker
 * Grants up to GRANT_NUM requests, lowest index first
 */

`timescale 1ns/1ps

`include "scheduler_consts.svh"

module Picker
    import SchedulerPkg::*;
#(
    parameter int ENTRY_NUM = `ISSUE_QUEUE_ENTRY_NUM,
    parameter int GRANT_NUM = 1
)(
    input IssueQueueOneHotPath req,
    output IssueQueueOneHotPath grant [GRANT_NUM],
    output IssueQueueIndexPath grantPtr [GRANT_NUM],
    output logic granted [GRANT_NUM]
);

    // Requests not yet taken by a lower slot
    IssueQueueOneHotPath remaining;

    always_comb begin
        remaining = req;
        for (int k = 0; k < GRANT_NUM; k++) begin
            grant[k] = '0;
            grantPtr[k] = '0;
            granted[k] = 1'b0;

            // Lowest remaining request wins this slot
            for (int i = 0; i < ENTRY_NUM; i++) begin
                if (remaining[i] && !granted[k]) begin
                    grant[k][i] = 1'b1;
                    grantPtr[k] = IssueQueueIndexPath'(i);
                    granted[k] = 1'b1;
                end
            end

            remaining = remaining & ~grant[k];
        end
    end

endmodule : Picker

// ==== verilog/SchedulerPkg.sv ====
/*
 * Scheduler types
 * Queue indices, tags, op classes and the op payload word
 */

`include "scheduler_consts.svh"

package SchedulerPkg;

    typedef logic [$clog2(`ISSUE_QUEUE_ENTRY_NUM)-1:0] IssueQueueIndexPath;
    typedef logic [`ISSUE_QUEUE_ENTRY_NUM-1:0] IssueQueueOneHotPath;

    typedef logic [`PREG_TAG_WIDTH-1:0] PRegTag;

    typedef enum logic {
        INT = 1'b0,
        MEM = 1'b1
    } OpClass;

    // Integer view of the payload
    typedef struct packed {
        logic [3:0] aluOpcode;
        logic [11:0] aluImm;
    } AluFields;

    // Memory view of the payload
    typedef struct packed {
        logic isStore;
        logic [1:0] accessSize;
        logic [12:0] offset;
    } MemFields;

    // One stored word, read as ALU or memory fields by lane
    typedef union packed {
        AluFields alu;
        MemFields mem;
    } OpPayload;

endpackage : SchedulerPkg

// ==== verilog/SelectLogic.sv ====
/*
 * Select logic
 * Forms per-class requests from ready entries and picks
 * up to two integer ops and one memory op per cycle
 */

`timescale 1ns/1ps

`include "scheduler_consts.svh"

module SelectLogic
    import SchedulerPkg::*;
(
    input IssueQueueOneHotPath opReady,
    input IssueQueueOneHotPath intIssueReq,
    input IssueQueueOneHotPath memIssueReq,
    input logic memReady,
    output logic selected [`ISSUE_WIDTH],
    output IssueQueueIndexPath selectedPtr [`ISSUE_WIDTH],
    output IssueQueueOneHotPath selectedVector [`ISSUE_WIDTH]
);

    IssueQueueOneHotPath intRequest;
    IssueQueueOneHotPath intGrant [`INT_ISSUE_WIDTH];
    IssueQueueIndexPath intGrantPtr [`INT_ISSUE_WIDTH];
    logic intGranted [`INT_ISSUE_WIDTH];

    IssueQueueOneHotPath memRequest;
    IssueQueueOneHotPath memGrant [`MEM_ISSUE_WIDTH];
    IssueQueueIndexPath memGrantPtr [`MEM_ISSUE_WIDTH];
    logic memGranted [`MEM_ISSUE_WIDTH];

    // Memory pipe stalled means no memory candidates at all
    assign intRequest = opReady & intIssueReq;
    assign memRequest = opReady & memIssueReq & {`ISSUE_QUEUE_ENTRY_NUM{memReady}};

    Picker #(
        .ENTRY_NUM(`ISSUE_QUEUE_ENTRY_NUM),
        .GRANT_NUM(`INT_ISSUE_WIDTH)
    ) intPicker (
        .req(intRequest),
        .grant(intGrant),
        .grantPtr(intGrantPtr),
        .granted(intGranted)
    );

    Picker #(
        .ENTRY_NUM(`ISSUE_QUEUE_ENTRY_NUM),
        .GRANT_NUM(`MEM_ISSUE_WIDTH)
    ) memPicker (
        .req(memRequest),
        .grant(memGrant),
        .grantPtr(memGrantPtr),
        .granted(memGranted)
    );

    // Lane order, integer lanes then memory
    always_comb begin
        for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
            selected[i] = intGranted[i];
            selectedPtr[i] = intGrantPtr[i];
            selectedVector[i] = intGrant[i];
        end
        for (int i = 0; i < `MEM_ISSUE_WIDTH; i++) begin
            selected[i+`INT_ISSUE_WIDTH] = memGranted[i];
            selectedPtr[i+`INT_ISSUE_WIDTH] = memGrantPtr[i];
            selectedVector[i+`INT_ISSUE_WIDTH] = memGrant[i];
        end
    end

endmodule : SelectLogic

// ==== verilog/WakeupLogic.sv ====
/*
 * Wakeup logic
 * Tracks source readiness per entry and matches broadcast tags
 */

`timescale 1ns/1ps

`include "scheduler_consts.svh"

module WakeupLogic
    import SchedulerPkg::*;
(
    input logic clk,
    input logic arstN,
    input logic flush,
    input logic allocValid,
    input IssueQueueIndexPath allocPtr,
    input PRegTag dispatchSrcTag [2],
    input logic dispatchSrcReady [2],
    input IssueQueueOneHotPath selectedVector [`ISSUE_WIDTH],
    input logic issueValid [`ISSUE_WIDTH],
    input PRegTag issueDstTag [`ISSUE_WIDTH],
    input logic extWakeupValid,
    input PRegTag extWakeupTag,
    output IssueQueueOneHotPath opReady
);

    PRegTag srcTag [`ISSUE_QUEUE_ENTRY_NUM][2];
    logic srcReady [`ISSUE_QUEUE_ENTRY_NUM][2];
    logic srcHit [`ISSUE_QUEUE_ENTRY_NUM][2];
    logic dispatchHit [2];
    IssueQueueOneHotPath freed;

    always_comb begin
        // Compare every stored and incoming tag against all broadcasts
        for (int s = 0; s < 2; s++) begin
            dispatchHit[s] = extWakeupValid && (extWakeupTag == dispatchSrcTag[s]);
            for (int k = 0; k < `ISSUE_WIDTH; k++) begin
                dispatchHit[s] |= issueValid[k] && (issueDstTag[k] == dispatchSrcTag[s]);
            end
            for (int i = 0; i < `ISSUE_QUEUE_ENTRY_NUM; i++) begin
                srcHit[i][s] = extWakeupValid && (extWakeupTag == srcTag[i][s]);
                for (int k = 0; k < `ISSUE_WIDTH; k++) begin
                    srcHit[i][s] |= issueValid[k] && (issueDstTag[k] == srcTag[i][s]);
                end
            end
        end

        freed = '0;
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            freed |= selectedVector[k];
        end

        for (int i = 0; i < `ISSUE_QUEUE_ENTRY_NUM; i++) begin
            opReady[i] = srcReady[i][0] && srcReady[i][1];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `ISSUE_QUEUE_ENTRY_NUM; i++) begin
                srcReady[i][0] <= 1'b0;
                srcReady[i][1] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `ISSUE_QUEUE_ENTRY_NUM; i++) begin
                for (int s = 0; s < 2; s++) begin
                    if (flush || freed[i]) begin
                        srcReady[i][s] <= 1'b0;
                    end else if (allocValid && (allocPtr == IssueQueueIndexPath'(i))) begin
                        srcReady[i][s] <= dispatchSrcReady[s] || dispatchHit[s];
                    end else if (srcHit[i][s]) begin
                        srcReady[i][s] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocValid) begin
            srcTag[allocPtr][0] <= dispatchSrcTag[0];
            srcTag[allocPtr][1] <= dispatchSrcTag[1];
        end
    end

endmodule : WakeupLogic
